/* test/datapath_tests.txt */
# name instr(hex) we rd data(hex) xcpt gap
# rd and data are checked only when we is 1, gap is idle cycles before the next strobe
addi_pos     12300093 1 1  00000123 0 0
addi_neg     fff00113 1 2  ffffffff 0 0
add_byp      002081b3 1 3  00000122 0 0
sub_dist3    40118233 1 4  ffffffff 0 0
xori_sext    5a524293 1 5  fffffa5a 0 0
andi_mask    7f02f313 1 6  00000250 0 1
ori_negimm   80036393 1 7  fffffa50 0 2
or_gap2      0013e433 1 8  fffffb73 0 0
and_to_x0    00247033 1 0  fffffb73 0 0
add_from_x0  001004b3 1 9  00000123 0 0
xor_mix      0054c533 1 10 fffffb79 0 1
csrrw_init   340490f3 1 1  00000000 0 0
csrrs_bits   3402a173 1 2  00000123 0 0
csrrc_bits   3404b1f3 1 3  fffffb7b 0 0
csrrs_read1  34002273 1 4  fffffa58 0 0
csrrwi_uimm  340fd2f3 1 5  fffffa58 0 0
csrrci_uimm  34057373 1 6  0000001f 0 0
csrrsi_uimm  340463f3 1 7  00000015 0 0
csrrs_read2  34002473 1 8  0000001d 0 0
addi_csr_byp 00140493 1 9  0000001e 0 0
minstret_rd1 b0202573 1 10 00000014 0 0
minstret_wr  b02490f3 0 0  00000000 1 0
illegal_op   deadbeef 0 0  00000000 1 0
csr_unknown  34102173 0 0  00000000 1 0
minstret_rd2 b02021f3 1 3  00000015 0 0
add_x1_kept  00008233 1 4  00000000 0 3
add_x2_kept  009102b3 1 5  00000141 0 0
addi_x0_src  7ff00313 1 6  000007ff 0 2
minstret_rd3 b02023f3 1 7  00000019 0 0

/* all.f */
hdl/core_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/exe_stage.sv
hdl/csr_unit.sv
hdl/datapath.sv
hdl/core_top.sv
test/datapath_tb.sv

/* Makefile */
SRCS := $(shell cat all.f)

all: run

obj_dir/Vdatapath_tb: all.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module datapath_tb -f all.f

run: obj_dir/Vdatapath_tb
	obj_dir/Vdatapath_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* test/datapath_tb.sv */
// testbench for core_top, replays the instruction list in the tests file and checks each commit
`default_nettype none

module datapath_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    localparam int clk_period = 4;
    localparam int max_tests  = 64;
    localparam int latency    = 3;

    typedef logic [8*16-1:0] name_t;

    // dut ports
    logic                  clk_i;
    logic                  rstn_i;
    logic                  instr_valid_i;
    instr_u                instr_i;
    logic                  commit_valid_o;
    logic                  commit_we_o;
    logic [reg_addr_w-1:0] commit_rd_o;
    logic [xlen-1:0]       commit_data_o;
    logic                  commit_xcpt_o;

    // test table, one entry per file line
    name_t                 names    [max_tests];
    instr_u                words    [max_tests];
    logic                  exp_we   [max_tests];
    logic [reg_addr_w-1:0] exp_rd   [max_tests];
    logic [xlen-1:0]       exp_data [max_tests];
    logic                  exp_xcpt [max_tests];
    int                    gaps     [max_tests];
    int                    num_tests;
    int                    total_gap;
    logic                  loaded;

    // strobes still waiting for their commit
    int                    pend_idx   [$];
    int                    pend_cycle [$];
    int                    cycle;
    int                    seen;
    int                    idx;
    int                    sent;
    int                    limit_ns;
    int                    i;
    int                    g;

    core_top core_top_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .commit_valid_o (commit_valid_o),
        .commit_we_o    (commit_we_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .commit_xcpt_o  (commit_xcpt_o)
    );

    always #(clk_period / 2) clk_i = ~clk_i;

    // cycle count, read by driver and monitor away from the edge
    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input name_t test, input string field,
                              input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Error %0s %0s: expected %08h, actual %08h",
                                test, field, exp, act));
        end
    endtask

    task automatic check_flag(input name_t test, input string field,
                              input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Error %0s %0s: expected %0b, actual %0b",
                                test, field, exp, act));
        end
    endtask

    task automatic match_rd(input name_t test, input logic [reg_addr_w-1:0] exp,
                            input logic [reg_addr_w-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Error %0s rd: expected x%0d, actual x%0d", test, exp, act));
        end
    endtask

    // reads name, word, we, rd, data, xcpt and gap from each non-comment line
    task automatic load_tests();
        int    fd;
        int    got;
        int    we;
        int    rd;
        int    xcpt;
        int    gap;
        string line;
        name_t name;
        logic [31:0]     word;
        logic [xlen-1:0] data;
        fd = $fopen("test/datapath_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open test/datapath_tests.txt");
        end
        num_tests = 0;
        total_gap = 0;
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%s %h %d %d %h %d %d",
                              name, word, we, rd, data, xcpt, gap);
                if (got != 7) begin
                    abort_run($sformatf("malformed line in the tests file: %0s", line));
                end
                if (num_tests >= max_tests) begin
                    abort_run("the tests file holds more tests than the table can take");
                end
                names[num_tests]    = name;
                words[num_tests]    = word;
                exp_we[num_tests]   = (we != 0);
                exp_rd[num_tests]   = rd[reg_addr_w-1:0];
                exp_data[num_tests] = data;
                exp_xcpt[num_tests] = (xcpt != 0);
                gaps[num_tests]     = gap;
                total_gap           = total_gap + gap;
                num_tests           = num_tests + 1;
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            abort_run("the tests file holds no tests");
        end
    endtask

    // driver, one strobe per test, then the idle gap
    initial begin
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        cycle         = 0;
        seen          = 0;
        loaded        = 1'b0;
        load_tests();
        limit_ns = (num_tests + total_gap + 20) * clk_period;
        loaded   = 1'b1;
        repeat (5) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        @(posedge clk_i);
        for (i = 0; i < num_tests; i++) begin
            #1;
            instr_valid_i = 1'b1;
            instr_i       = words[i];
            pend_idx.push_back(i);
            pend_cycle.push_back(cycle);
            @(posedge clk_i);
            for (g = 0; g < gaps[i]; g++) begin
                #1;
                instr_valid_i = 1'b0;
                instr_i       = '0;
                @(posedge clk_i);
            end
        end
        #1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        wait (seen == num_tests);
        // a couple of quiet cycles to catch a stray commit
        repeat (2) @(posedge clk_i);
        $display("SIMULATION PASSED");
        $finish;
    end

    // monitor, samples mid cycle where commit outputs are settled
    always @(negedge clk_i) begin
        if (rstn_i && commit_valid_o) begin
            if (pend_idx.size() == 0) begin
                abort_run("a commit came out with no instruction outstanding");
            end else begin
                idx  = pend_idx.pop_front();
                sent = pend_cycle.pop_front();
                if (cycle != sent + latency) begin
                    abort_run($sformatf("Error %0s latency: expected cycle %0d, actual %0d",
                                        names[idx], sent + latency, cycle));
                end
                check_flag(names[idx], "we", exp_we[idx], commit_we_o);
                check_flag(names[idx], "xcpt", exp_xcpt[idx], commit_xcpt_o);
                // rd and data mean something only on a write
                if (exp_we[idx]) begin
                    match_rd(names[idx], exp_rd[idx], commit_rd_o);
                    check_data(names[idx], "data", exp_data[idx], commit_data_o);
                end
                seen = seen + 1;
            end
        end
    end

    // watchdog sized from the number of tests and their gaps
    initial begin
        wait (loaded);
        #(limit_ns);
        abort_run($sformatf("timeout: only %0d of %0d commits seen after %0d ns",
                            seen, num_tests, limit_ns));
    end

endmodule

`default_nettype wire

/* hdl/core_top.sv */
// core top level, joins the datapath with the csr unit behind the instruction and commit ports
`default_nettype none

module core_top (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  wire                                 instr_valid_i,
    input  wire core_pkg::instr_u               instr_i,
    output logic                                commit_valid_o,
    output logic                                commit_we_o,
    output logic [core_pkg::reg_addr_w-1:0]     commit_rd_o,
    output logic [core_pkg::xlen-1:0]           commit_data_o,
    output logic                                commit_xcpt_o
);
    import core_pkg::*;

    // writeback request and same cycle answer
    logic                  csr_ena;
    csr_cmd_t              csr_cmd;
    logic [csr_addr_w-1:0] csr_addr;
    logic [xlen-1:0]       csr_wdata;
    logic [xlen-1:0]       csr_rdata;
    logic                  csr_xcpt;
    logic                  retire;

    datapath datapath_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .csr_rdata_i    (csr_rdata),
        .csr_xcpt_i     (csr_xcpt),
        .csr_ena_o      (csr_ena),
        .csr_cmd_o      (csr_cmd),
        .csr_addr_o     (csr_addr),
        .csr_wdata_o    (csr_wdata),
        .retire_o       (retire),
        .commit_valid_o (commit_valid_o),
        .commit_we_o    (commit_we_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .commit_xcpt_o  (commit_xcpt_o)
    );

    csr_unit csr_unit_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .ena_i    (csr_ena),
        .cmd_i    (csr_cmd),
        .addr_i   (csr_addr),
        .wdata_i  (csr_wdata),
        .retire_i (retire),
        .rdata_o  (csr_rdata),
        .xcpt_o   (csr_xcpt)
    );

endmodule

`default_nettype wire

/* hdl/datapath.sv */
// in-order rv32 datapath: decode, register read, execute and writeback with csr commands
`default_nettype none

module datapath (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  wire                                 instr_valid_i,
    input  wire core_pkg::instr_u               instr_i,
    input  wire [core_pkg::xlen-1:0]            csr_rdata_i,
    input  wire                                 csr_xcpt_i,
    output logic                                csr_ena_o,
    output core_pkg::csr_cmd_t                  csr_cmd_o,
    output logic [core_pkg::csr_addr_w-1:0]     csr_addr_o,
    output logic [core_pkg::xlen-1:0]           csr_wdata_o,
    output logic                                retire_o,
    output logic                                commit_valid_o,
    output logic                                commit_we_o,
    output logic [core_pkg::reg_addr_w-1:0]     commit_rd_o,
    output logic [core_pkg::xlen-1:0]           commit_data_o,
    output logic                                commit_xcpt_o
);
    import core_pkg::*;

    // decode, straight from the decoder
    logic                  id_valid, id_illegal, id_use_imm, id_we, id_is_csr, id_csr_imm;
    logic [reg_addr_w-1:0] id_rd, id_rs1, id_rs2;
    logic [xlen-1:0]       id_imm;
    alu_op_t               id_alu_op;
    logic [2:0]            id_funct3;
    // register read
    logic                  rr_valid, rr_illegal, rr_use_imm, rr_we, rr_is_csr, rr_csr_imm;
    logic [reg_addr_w-1:0] rr_rd, rr_rs1, rr_rs2;
    logic [xlen-1:0]       rr_imm, rr_data1, rr_data2;
    alu_op_t               rr_alu_op;
    logic [2:0]            rr_funct3;
    logic [csr_addr_w-1:0] rr_csr_addr;
    // execute
    logic                  ex_valid, ex_illegal, ex_use_imm, ex_we, ex_is_csr, ex_csr_imm;
    logic [reg_addr_w-1:0] ex_rd, ex_rs1, ex_rs2;
    logic [xlen-1:0]       ex_imm, ex_data1, ex_data2, ex_result;
    alu_op_t               ex_alu_op;
    logic [2:0]            ex_funct3;
    logic [csr_addr_w-1:0] ex_csr_addr;
    // writeback
    logic                  wb_valid, wb_illegal, wb_we, wb_is_csr, wb_csr_imm;
    logic                  wb_xcpt, wb_rf_we;
    logic [reg_addr_w-1:0] wb_rd, wb_rs1;
    logic [xlen-1:0]       wb_result, wb_data;
    logic [2:0]            wb_funct3;
    logic [csr_addr_w-1:0] wb_csr_addr;

    decoder decoder_i (
        .instr_i   (instr_i),
        .valid_i   (instr_valid_i),
        .valid_o   (id_valid),
        .illegal_o (id_illegal),
        .rd_o      (id_rd),
        .rs1_o     (id_rs1),
        .rs2_o     (id_rs2),
        .use_imm_o (id_use_imm),
        .imm_o     (id_imm),
        .alu_op_o  (id_alu_op),
        .we_o      (id_we),
        .is_csr_o  (id_is_csr),
        .csr_imm_o (id_csr_imm),
        .funct3_o  (id_funct3)
    );

    // valid bits, the only reset state of the pipe
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            rr_valid <= 1'b0;
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            rr_valid <= id_valid;
            ex_valid <= rr_valid;
            wb_valid <= ex_valid;
        end
    end

    // payload moves every cycle, qualified by valid
    always_ff @(posedge clk_i) begin
        // decode to register read; csr address is the i-type imm field
        {rr_illegal, rr_use_imm, rr_we, rr_is_csr, rr_csr_imm} <=
            {id_illegal, id_use_imm, id_we, id_is_csr, id_csr_imm};
        {rr_rd, rr_rs1, rr_rs2, rr_imm} <= {id_rd, id_rs1, id_rs2, id_imm};
        rr_alu_op   <= id_alu_op;
        rr_funct3   <= id_funct3;
        rr_csr_addr <= instr_i.i_view.imm12;
        // register read to execute
        {ex_illegal, ex_use_imm, ex_we, ex_is_csr, ex_csr_imm} <=
            {rr_illegal, rr_use_imm, rr_we, rr_is_csr, rr_csr_imm};
        {ex_rd, ex_rs1, ex_rs2, ex_imm} <= {rr_rd, rr_rs1, rr_rs2, rr_imm};
        {ex_data1, ex_data2} <= {rr_data1, rr_data2};
        ex_alu_op   <= rr_alu_op;
        ex_funct3   <= rr_funct3;
        ex_csr_addr <= rr_csr_addr;
        // execute to writeback
        {wb_illegal, wb_we, wb_is_csr, wb_csr_imm} <= {ex_illegal, ex_we, ex_is_csr, ex_csr_imm};
        {wb_rd, wb_rs1, wb_result} <= {ex_rd, ex_rs1, ex_result};
        wb_funct3   <= ex_funct3;
        wb_csr_addr <= ex_csr_addr;
    end

    // distance two hazards are covered by the write-through
    regfile regfile_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (wb_rf_we),
        .waddr_i  (wb_rd),
        .wdata_i  (wb_data),
        .raddr1_i (rr_rs1),
        .raddr2_i (rr_rs2),
        .rdata1_o (rr_data1),
        .rdata2_o (rr_data2)
    );

    exe_stage exe_stage_i (
        .rs1_i       (ex_rs1),
        .rs2_i       (ex_rs2),
        .data1_i     (ex_data1),
        .data2_i     (ex_data2),
        .use_imm_i   (ex_use_imm),
        .imm_i       (ex_imm),
        .alu_op_i    (ex_alu_op),
        .byp_valid_i (wb_rf_we),
        .byp_rd_i    (wb_rd),
        .byp_data_i  (wb_data),
        .result_o    (ex_result)
    );

    // csr command; zero rs1 or uimm turns set and clear into a plain read
    always_comb begin
        case ({1'b0, wb_funct3[1:0]})
            f3_csrrw: csr_cmd_o = csr_cmd_write;
            f3_csrrs: csr_cmd_o = (wb_rs1 == '0) ? csr_cmd_read : csr_cmd_set;
            f3_csrrc: csr_cmd_o = (wb_rs1 == '0) ? csr_cmd_read : csr_cmd_clear;
            default:  csr_cmd_o = csr_cmd_read;
        endcase
    end

    assign csr_ena_o   = wb_valid && wb_is_csr && !wb_illegal;
    assign csr_addr_o  = csr_ena_o ? wb_csr_addr : '0;
    // uimm form carries the 5-bit field in the rs1 slot
    assign csr_wdata_o = wb_csr_imm ? {{(xlen-reg_addr_w){1'b0}}, wb_rs1} : wb_result;

    // bad encoding or a rejected csr access
    assign wb_xcpt  = wb_valid && (wb_illegal || csr_xcpt_i);
    assign wb_rf_we = wb_valid && wb_we && !wb_xcpt;
    assign retire_o = wb_valid && !wb_xcpt;
    assign wb_data  = wb_is_csr ? csr_rdata_i : wb_result;

    assign commit_valid_o = wb_valid;
    assign commit_we_o    = wb_rf_we;
    assign commit_rd_o    = wb_rd;
    assign commit_data_o  = wb_data;
    assign commit_xcpt_o  = wb_xcpt;

    // faulting commit neither writes nor retires
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_xcpt_o |-> (!commit_we_o && !retire_o));

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
// machine csr file with mscratch and minstret, serves the writeback command of the datapath
`default_nettype none

module csr_unit (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  wire                                 ena_i,
    input  wire core_pkg::csr_cmd_t             cmd_i,
    input  wire [core_pkg::csr_addr_w-1:0]      addr_i,
    input  wire [core_pkg::xlen-1:0]            wdata_i,
    input  wire                                 retire_i,
    output logic [core_pkg::xlen-1:0]           rdata_o,
    output logic                                xcpt_o
);
    import core_pkg::*;

    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] minstret;
    logic [xlen-1:0] mscratch_next;
    logic            hit_mscratch;
    logic            hit_minstret;
    logic            is_write;

    assign hit_mscratch = addr_i == csr_mscratch;
    assign hit_minstret = addr_i == csr_minstret;
    // set and clear count as writes, read does not
    assign is_write     = cmd_i != csr_cmd_read;

    // old value goes back to rd
    always_comb begin
        rdata_o = '0;
        if (hit_mscratch) begin
            rdata_o = mscratch;
        end else if (hit_minstret) begin
            rdata_o = minstret;
        end
    end

    // minstret is read only, anything unmapped faults
    assign xcpt_o = ena_i && (hit_minstret ? is_write : !hit_mscratch);

    always_comb begin
        case (cmd_i)
            csr_cmd_write: mscratch_next = wdata_i;
            csr_cmd_set:   mscratch_next = mscratch | wdata_i;
            csr_cmd_clear: mscratch_next = mscratch & ~wdata_i;
            default:       mscratch_next = mscratch;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            mscratch <= '0;
            minstret <= '0;
        end else begin
            if (ena_i && !xcpt_o && hit_mscratch && is_write) begin
                mscratch <= mscratch_next;
            end
            // a csr read of minstret sees the count before itself
            if (retire_i) begin
                minstret <= minstret + 1'b1;
            end
        end
    end

    // faulting access changes nothing, so the datapath must hold retire low too
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        xcpt_o |=> ($stable(mscratch) && $stable(minstret)));

endmodule

`default_nettype wire

/* hdl/exe_stage.sv */
// execute stage alu, takes the writeback value in place of a stale register operand
`default_nettype none

module exe_stage (
    input  wire [core_pkg::reg_addr_w-1:0]      rs1_i,
    input  wire [core_pkg::reg_addr_w-1:0]      rs2_i,
    input  wire [core_pkg::xlen-1:0]            data1_i,
    input  wire [core_pkg::xlen-1:0]            data2_i,
    input  wire                                 use_imm_i,
    input  wire [core_pkg::xlen-1:0]            imm_i,
    input  wire core_pkg::alu_op_t              alu_op_i,
    input  wire                                 byp_valid_i,
    input  wire [core_pkg::reg_addr_w-1:0]      byp_rd_i,
    input  wire [core_pkg::xlen-1:0]            byp_data_i,
    output logic [core_pkg::xlen-1:0]           result_o
);
    import core_pkg::*;

    logic            byp_hit1;
    logic            byp_hit2;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] src2;

    // bypass only a real register, x0 has no producer
    assign byp_hit1 = byp_valid_i && (byp_rd_i != '0) && (byp_rd_i == rs1_i);
    assign byp_hit2 = byp_valid_i && (byp_rd_i != '0) && (byp_rd_i == rs2_i);

    assign op_a = byp_hit1 ? byp_data_i : data1_i;
    assign src2 = byp_hit2 ? byp_data_i : data2_i;
    // i-type and csr use the immediate, zero for csr
    assign op_b = use_imm_i ? imm_i : src2;

    always_comb begin
        case (alu_op_i)
            alu_add: result_o = op_a + op_b;
            alu_sub: result_o = op_a - op_b;
            alu_and: result_o = op_a & op_b;
            alu_or:  result_o = op_a | op_b;
            alu_xor: result_o = op_a ^ op_b;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/regfile.sv */
// integer register file, two combinational read ports with write-through, one clocked write port
`default_nettype none

module regfile (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  wire                                 we_i,
    input  wire [core_pkg::reg_addr_w-1:0]      waddr_i,
    input  wire [core_pkg::xlen-1:0]            wdata_i,
    input  wire [core_pkg::reg_addr_w-1:0]      raddr1_i,
    input  wire [core_pkg::reg_addr_w-1:0]      raddr2_i,
    output logic [core_pkg::xlen-1:0]           rdata1_o,
    output logic [core_pkg::xlen-1:0]           rdata2_o
);
    import core_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];
    logic            wr_live;

    // writes to x0 are dropped here
    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same cycle write shows up on the read ports
    assign rdata1_o = (wr_live && (waddr_i == raddr1_i)) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (wr_live && (waddr_i == raddr2_i)) ? wdata_i : regs[raddr2_i];

    // x0 stays zero even with a forwarded write to it
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (raddr1_i == '0) |-> (rdata1_o == '0));
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (raddr2_i == '0) |-> (rdata2_o == '0));

endmodule

`default_nettype wire

/* hdl/decoder.sv */
// combinational rv32 decoder, turns a strobed instruction word into the decode stage entry
`default_nettype none

module decoder (
    input  wire core_pkg::instr_u               instr_i,
    input  wire                                 valid_i,
    output logic                                valid_o,
    output logic                                illegal_o,
    output logic [core_pkg::reg_addr_w-1:0]     rd_o,
    output logic [core_pkg::reg_addr_w-1:0]     rs1_o,
    output logic [core_pkg::reg_addr_w-1:0]     rs2_o,
    output logic                                use_imm_o,
    output logic [core_pkg::xlen-1:0]           imm_o,
    output core_pkg::alu_op_t                   alu_op_o,
    output logic                                we_o,
    output logic                                is_csr_o,
    output logic                                csr_imm_o,
    output logic [2:0]                          funct3_o
);
    import core_pkg::*;

    assign valid_o = valid_i;

    always_comb begin
        // defaults describe a harmless add of x0
        rd_o      = '0;
        rs1_o     = '0;
        rs2_o     = '0;
        use_imm_o = 1'b0;
        imm_o     = '0;
        alu_op_o  = alu_add;
        we_o      = 1'b0;
        is_csr_o  = 1'b0;
        csr_imm_o = 1'b0;
        funct3_o  = instr_i.r_view.funct3;
        illegal_o = 1'b0;
        case (instr_i.r_view.opcode)
            op_reg: begin
                rd_o  = instr_i.r_view.rd;
                rs1_o = instr_i.r_view.rs1;
                rs2_o = instr_i.r_view.rs2;
                we_o  = 1'b1;
                // funct7 must be zero apart from sub
                case (instr_i.r_view.funct3)
                    f3_add: begin
                        alu_op_o  = (instr_i.r_view.funct7 == funct7_sub) ? alu_sub : alu_add;
                        illegal_o = (instr_i.r_view.funct7 != funct7_sub) &&
                                    (instr_i.r_view.funct7 != '0);
                    end
                    f3_xor: begin
                        alu_op_o  = alu_xor;
                        illegal_o = instr_i.r_view.funct7 != '0;
                    end
                    f3_or: begin
                        alu_op_o  = alu_or;
                        illegal_o = instr_i.r_view.funct7 != '0;
                    end
                    f3_and: begin
                        alu_op_o  = alu_and;
                        illegal_o = instr_i.r_view.funct7 != '0;
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            op_imm: begin
                rd_o      = instr_i.i_view.rd;
                rs1_o     = instr_i.i_view.rs1;
                use_imm_o = 1'b1;
                we_o      = 1'b1;
                imm_o     = {{(xlen-12){instr_i.i_view.imm12[11]}}, instr_i.i_view.imm12};
                case (instr_i.i_view.funct3)
                    f3_add:  alu_op_o = alu_add;
                    f3_xor:  alu_op_o = alu_xor;
                    f3_or:   alu_op_o = alu_or;
                    f3_and:  alu_op_o = alu_and;
                    default: illegal_o = 1'b1;
                endcase
            end
            op_system: begin
                // rs1 + 0 through the alu gives the csr source
                rd_o      = instr_i.i_view.rd;
                rs1_o     = instr_i.i_view.rs1;
                use_imm_o = 1'b1;
                we_o      = 1'b1;
                is_csr_o  = 1'b1;
                csr_imm_o = instr_i.i_view.funct3[2];
                // ecall, ebreak and xret are not supported
                illegal_o = instr_i.i_view.funct3[1:0] == 2'b00;
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
// shared widths, rv32 encodings and the instruction word type, compiled ahead of every module
`default_nettype none

package core_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_system = 7'b1110011;

    // alu funct3 codes, shared by r and i forms
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    // csr funct3 codes; bit 2 set picks the uimm form
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;
    localparam logic [2:0] f3_csrrc = 3'b011;

    // only funct7 other than zero we accept
    localparam logic [6:0] funct7_sub = 7'b0100000;

    // implemented csrs
    localparam logic [csr_addr_w-1:0] csr_mscratch = 12'h340;
    localparam logic [csr_addr_w-1:0] csr_minstret = 12'hB02;

    typedef enum logic [1:0] {
        csr_cmd_read,
        csr_cmd_write,
        csr_cmd_set,
        csr_cmd_clear
    } csr_cmd_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    // one 32-bit word, seen as r-type or i-type
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i_view;
    } instr_u;

endpackage

`default_nettype wire
